//--- gpu_cluster.f
source/cluster_cfg_pkg.sv
source/mem_types_pkg.sv
source/cluster_dcr_regs.sv
source/mem_mux.sv
source/outstanding_tracker.sv
source/gpu_cluster.sv
testbench/tb_clock_gen.sv
testbench/gpu_cluster_assert.sv
testbench/gpu_cluster_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass message in the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module gpu_cluster_tb \
    -f gpu_cluster.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vgpu_cluster_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit 1
fi

if grep -q "^Simulation completed successfully$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- testbench/gpu_cluster_tests.txt
# C dcr_addr dcr_data : configuration write
# R core op addr data tag expected_read_data : queue a core request (op 0 read, 1 write)
# G count order : start queued requests, expect count memory requests in core order
C 1 00000000
R 0 1 00000100 11112222 1 00000000
R 1 1 00000200 33334444 2 00000000
G 2 01
R 0 0 00000100 00000000 3 11112222
R 1 0 00000200 00000000 4 33334444
R 2 0 00000300 00000000 5 FFFFFCFF
R 3 0 00000100 00000000 6 11112222
G 4 2301
C 1 00000001
R 0 0 00000200 00000000 1 33334444
R 1 0 00000300 00000000 2 FFFFFCFF
R 2 0 00000100 00000000 3 11112222
R 3 0 00000200 00000000 4 33334444
G 4 0123
C 0 0000000B
R 2 0 00000100 00000000 7 11112222
R 0 1 00000400 AAAA0000 8 00000000
R 1 0 00000400 00000000 9 AAAA0000
R 3 0 00000200 00000000 A 33334444
G 3 013
C 5 0000000F
G 0 0
C 0 0000000F
G 1 2
C 1 00000000
R 0 1 00000500 55555555 1 00000000
R 0 0 00000100 00000000 2 11112222
R 1 0 00000500 00000000 3 55555555
R 1 0 00000200 00000000 4 33334444
R 2 0 00000400 00000000 5 AAAA0000
R 2 0 00000600 00000000 6 FFFFF9FF
R 3 0 00000300 00000000 7 FFFFFCFF
R 3 1 00000700 77777777 8 00000000
G 8 30123012

//--- testbench/gpu_cluster_tb.sv
`timescale 1ns/10ps

module gpu_cluster_tb
    import cluster_cfg_pkg::*;
    import mem_types_pkg::*;
();

    localparam int NUM_CORES = 4;

    typedef struct packed {
        core_req_t   req;
        logic [31:0] exp; // expected read data.
    } core_item_t;

    typedef struct packed {
        logic [MEM_TAG_BITS-1:0] tag;
        logic [31:0]             data;
        logic [31:0]             exp;
        logic [31:0]             due;
    } mem_item_t;

    logic clk, rst_n, dcr_wr_valid, mem_req_valid, mem_req_ready;
    logic mem_rsp_valid, mem_rsp_ready, busy;
    dcr_addr_e dcr_wr_addr;
    logic [31:0] dcr_wr_data;
    logic [NUM_CORES-1:0] core_req_valid, core_req_ready, core_rsp_valid, core_rsp_ready;
    core_req_t core_req [NUM_CORES];
    core_rsp_t core_rsp [NUM_CORES];
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    core_item_t req_q [NUM_CORES][$];
    core_item_t sent_q [NUM_CORES][$];
    mem_item_t pend_q [$];
    logic [31:0] mem_model [logic [31:0]];
    logic [31:0] seed = 32'h2c58;
    int unsigned cycle_cnt = 0;
    int unsigned cycle_limit = 0;
    int unsigned grp_count = 0;
    int unsigned grp_n = 0;
    logic [31:0] grp_order = '0;
    logic dcr_pend = 1'b0;
    dcr_addr_e dcr_addr_v = DCR_CORE_ENABLE;
    logic [31:0] dcr_data_v = '0;

    tb_clock_gen clock_i (.clk(clk), .rst_n(rst_n));

    gpu_cluster #(.NUM_CORES(NUM_CORES)) dut_i (.*);

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed >> 16; // low bits of an LCG repeat quickly.
    endfunction

    task automatic fail_run();
        $display("Simulation failed");
        $fatal(1, "stopped at the first error.");
    endtask

    task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
        assert (got === exp) else begin
            $display("Error: time %0t, %s is %h, expected %h", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_true(logic cond, string what);
        assert (cond) else begin
            $display("At time %0t: %s", $time, what);
            fail_run();
        end
    endtask

    // **************************************************
    // memory model and response checks
    // **************************************************

    task automatic take_mem_request();
        core_item_t item;
        logic [CORE_IDX_BITS-1:0] core;
        logic [3:0] nib;
        core = mem_req.tag[MEM_TAG_BITS-1 -: CORE_IDX_BITS];
        check_true(grp_count < grp_n, "a memory request arrived that the test did not expect.");
        nib = 4'((grp_order >> (4 * (grp_n - 1 - grp_count))) & 32'hF);
        check_value("mem_req core index", 64'(core), 64'(nib));
        check_true(sent_q[core].size() > 0, "a memory request names a core with nothing sent.");
        item = sent_q[core].pop_front();
        check_value("mem_req.op", 64'(mem_req.op), 64'(item.req.op));
        check_value("mem_req.addr", 64'(mem_req.addr), 64'(item.req.addr));
        check_value("mem_req.data", 64'(mem_req.data), 64'(item.req.data));
        check_value("mem_req.tag", 64'(mem_req.tag[CORE_TAG_BITS-1:0]), 64'(item.req.tag));
        grp_count++;
        if (mem_req.op == MEM_WRITE) begin
            mem_model[mem_req.addr] = mem_req.data;
        end else begin
            pend_q.push_back('{tag: mem_req.tag,
                               data: mem_model.exists(mem_req.addr) ?
                                     mem_model[mem_req.addr] : ~mem_req.addr,
                               exp: item.exp,
                               due: 32'(cycle_cnt + 1 + next_random() % 5)});
        end
    endtask

    task automatic take_response();
        mem_item_t item;
        logic [CORE_IDX_BITS-1:0] core;
        item = pend_q.pop_front();
        core = item.tag[MEM_TAG_BITS-1 -: CORE_IDX_BITS];
        check_value("core_rsp_valid", 64'(core_rsp_valid), 64'(1) << core);
        check_value("core_rsp.data", 64'(core_rsp[core].data), 64'(item.exp));
        check_value("core_rsp.tag", 64'(core_rsp[core].tag), 64'(item.tag[CORE_TAG_BITS-1:0]));
    endtask

    // **************************************************
    // one clock cycle
    // **************************************************

    task automatic step();
        logic [CORE_IDX_BITS-1:0] rsp_idx;
        @(negedge clk);
        cycle_cnt++;
        check_true(cycle_cnt <= cycle_limit, "timeout, the run took too many cycles.");
        dcr_wr_valid = dcr_pend;
        dcr_wr_addr  = dcr_addr_v;
        dcr_wr_data  = dcr_data_v;
        dcr_pend     = 1'b0;
        for (int i = 0; i < NUM_CORES; i++) begin
            core_req_valid[i] = req_q[i].size() > 0;
            core_req[i]       = core_req_valid[i] ? req_q[i][0].req : '0;
            core_rsp_ready[i] = next_random() % 4 != 0;
        end
        mem_req_ready = next_random() % 4 != 0; // stalls about a quarter of the cycles.
        if (pend_q.size() > 0 && pend_q[0].due <= cycle_cnt) begin
            mem_rsp_valid = 1'b1;
            mem_rsp       = '{data: pend_q[0].data, tag: pend_q[0].tag};
        end else begin
            mem_rsp_valid = 1'b0;
            mem_rsp       = '0;
        end
        #5; // outputs are settled well before the next rising edge.
        for (int i = 0; i < NUM_CORES; i++) begin
            if (core_req_valid[i] && core_req_ready[i]) begin
                sent_q[i].push_back(req_q[i].pop_front());
            end
        end
        if (mem_req_valid && mem_req_ready) take_mem_request();
        if (mem_rsp_valid) begin
            rsp_idx = mem_rsp.tag[MEM_TAG_BITS-1 -: CORE_IDX_BITS];
            check_value("mem_rsp_ready", 64'(mem_rsp_ready), 64'(core_rsp_ready[rsp_idx]));
        end
        if (mem_rsp_valid && mem_rsp_ready) take_response();
        if (pend_q.size() > 0) check_value("busy", 64'(busy), 64'(1));
    endtask

    task automatic run_group(int unsigned n, logic [31:0] order);
        grp_n     = n;
        grp_order = order;
        grp_count = 0;
        while (grp_count < n || pend_q.size() > 0 || mem_req_valid) begin
            step();
        end
        repeat (4) step(); // nothing more may leak from disabled cores.
        for (int i = 0; i < NUM_CORES; i++) begin
            check_true(sent_q[i].size() == 0, "a request was accepted but never reached memory.");
        end
        check_value("busy", 64'(busy), 64'(0));
    endtask

    initial begin
        int fd;
        int n_lines;
        string line;
        byte cmd;
        logic [31:0] a, b, c, d, e, f;
        dcr_wr_valid   = 1'b0;
        dcr_wr_addr    = DCR_CORE_ENABLE;
        dcr_wr_data    = '0;
        core_req_valid = '0;
        core_rsp_ready = '0;
        mem_req_ready  = 1'b0;
        mem_rsp_valid  = 1'b0;
        mem_rsp        = '0;
        for (int i = 0; i < NUM_CORES; i++) core_req[i] = '0;
        n_lines = 0;
        fd = $fopen("testbench/gpu_cluster_tests.txt", "r");
        check_true(fd != 0, "the test file could not be opened.");
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#") n_lines++;
        end
        $fclose(fd);
        cycle_limit = 200 * n_lines;
        @(posedge rst_n);
        step();
        check_value("busy", 64'(busy), 64'(0));
        fd = $fopen("testbench/gpu_cluster_tests.txt", "r");
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#") begin
                void'($sscanf(line, "%c %h %h %h %h %h %h", cmd, a, b, c, d, e, f));
                if (cmd == "C") begin
                    dcr_pend   = 1'b1;
                    dcr_addr_v = dcr_addr_e'(a[3:0]);
                    dcr_data_v = b;
                    step();
                end else if (cmd == "R") begin
                    req_q[a].push_back('{req: '{op: mem_op_e'(b[0]), addr: c, data: d,
                                                tag: e[CORE_TAG_BITS-1:0]}, exp: f});
                end else if (cmd == "G") begin
                    run_group(a, b);
                end else begin
                    check_true(1'b0, "the test file holds an unknown command.");
                end
            end
        end
        $fclose(fd);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- testbench/gpu_cluster_assert.sv
`timescale 1ns/10ps

module gpu_cluster_assert
    import mem_types_pkg::*;
#(
    parameter int NUM_CORES = 4
) (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 mem_req_valid,
    input logic                 mem_req_ready,
    input mem_req_t             mem_req,
    input logic                 slot_full,
    input logic [NUM_CORES-1:0] core_req_ready
);

    // **************************************************
    // handshake rules
    // **************************************************

    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
        else $error("mem_req changed while the memory stalled it.");

    a_no_grant_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        slot_full && !mem_req_ready |-> core_req_ready == '0)
        else $error("a core was granted while the output slot was stalled.");

    // the busy source inside the multiplexer is the slot.
    a_idle_after_reset: assert property (@(posedge clk)
        !rst_n |=> !slot_full)
        else $error("the output slot is not empty after reset.");

endmodule

bind mem_mux gpu_cluster_assert #(
    .NUM_CORES (NUM_CORES)
) assert_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_req        (mem_req),
    .slot_full      (slot_full),
    .core_req_ready (core_req_ready)
);

//--- testbench/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1; // released away from the sampling edge.
    end

endmodule

//--- source/gpu_cluster.sv
`timescale 1ns/10ps

module gpu_cluster
    import cluster_cfg_pkg::*;
    import mem_types_pkg::*;
#(
    parameter int NUM_CORES = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,

    // configuration write
    input  logic                     dcr_wr_valid,
    input  dcr_addr_e                dcr_wr_addr,
    input  logic [DCR_DATA_BITS-1:0] dcr_wr_data,

    // core requests and responses
    input  logic [NUM_CORES-1:0]     core_req_valid,
    input  core_req_t                core_req [NUM_CORES],
    output logic [NUM_CORES-1:0]     core_req_ready,
    output logic [NUM_CORES-1:0]     core_rsp_valid,
    output core_rsp_t                core_rsp [NUM_CORES],
    input  logic [NUM_CORES-1:0]     core_rsp_ready,

    // memory port
    output logic                     mem_req_valid,
    output mem_req_t                 mem_req,
    input  logic                     mem_req_ready,
    input  logic                     mem_rsp_valid,
    input  mem_rsp_t                 mem_rsp,
    output logic                     mem_rsp_ready,

    // status
    output logic                     busy
);

    localparam int CNT_BITS = 4; // room for up to fifteen reads in flight per core.

    logic [NUM_CORES-1:0] core_enable;
    arb_mode_e            arb_mode;
    logic                 slot_full;

    cluster_dcr_regs #(
        .NUM_CORES (NUM_CORES)
    ) dcr_regs_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .dcr_wr_valid (dcr_wr_valid),
        .dcr_wr_addr  (dcr_wr_addr),
        .dcr_wr_data  (dcr_wr_data),
        .core_enable  (core_enable),
        .arb_mode     (arb_mode)
    );

    mem_mux #(
        .NUM_CORES (NUM_CORES)
    ) mem_mux_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .core_req_ready (core_req_ready),
        .core_enable    (core_enable),
        .arb_mode       (arb_mode),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_req_ready  (mem_req_ready),
        .slot_full      (slot_full),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp        (mem_rsp),
        .mem_rsp_ready  (mem_rsp_ready),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp),
        .core_rsp_ready (core_rsp_ready)
    );

    outstanding_tracker #(
        .NUM_CORES (NUM_CORES),
        .CNT_BITS  (CNT_BITS)
    ) tracker_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .core_req_valid (core_req_valid),
        .core_req_ready (core_req_ready),
        .core_req       (core_req),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp_ready (core_rsp_ready),
        .slot_full      (slot_full),
        .busy           (busy)
    );

endmodule

//--- source/outstanding_tracker.sv
`timescale 1ns/10ps

module outstanding_tracker
    import mem_types_pkg::*;
#(
    parameter int NUM_CORES = 4,
    parameter int CNT_BITS  = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,

    input  logic [NUM_CORES-1:0] core_req_valid,
    input  logic [NUM_CORES-1:0] core_req_ready,
    input  core_req_t            core_req [NUM_CORES],
    input  logic [NUM_CORES-1:0] core_rsp_valid,
    input  logic [NUM_CORES-1:0] core_rsp_ready,
    input  logic                 slot_full,

    output logic                 busy
);

    logic [NUM_CORES-1:0] cnt_nonzero;

    for (genvar i = 0; i < NUM_CORES; i++) begin : g_core
        logic [CNT_BITS-1:0] cnt;
        logic                rd_accept;
        logic                rsp_done;

        assign rd_accept = core_req_valid[i] && core_req_ready[i] && (core_req[i].op == MEM_READ);
        assign rsp_done  = core_rsp_valid[i] && core_rsp_ready[i];

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                cnt <= '0;
            end else if (rd_accept && !rsp_done) begin
                cnt <= cnt + 1'b1;
            end else if (rsp_done && !rd_accept) begin
                cnt <= cnt - 1'b1;
            end
        end

        assign cnt_nonzero[i] = |cnt;
    end

    assign busy = (|cnt_nonzero) || slot_full; // a write waiting in the slot also counts.

endmodule

//--- source/mem_mux.sv
`timescale 1ns/10ps

module mem_mux
    import cluster_cfg_pkg::*;
    import mem_types_pkg::*;
#(
    parameter int NUM_CORES = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,

    // core request side
    input  logic [NUM_CORES-1:0] core_req_valid,
    input  core_req_t            core_req [NUM_CORES],
    output logic [NUM_CORES-1:0] core_req_ready,

    // steering from the configuration registers
    input  logic [NUM_CORES-1:0] core_enable,
    input  arb_mode_e            arb_mode,

    // memory request side
    output logic                 mem_req_valid,
    output mem_req_t             mem_req,
    input  logic                 mem_req_ready,
    output logic                 slot_full,

    // memory response side
    input  logic                 mem_rsp_valid,
    input  mem_rsp_t             mem_rsp,
    output logic                 mem_rsp_ready,

    // core response side
    output logic [NUM_CORES-1:0] core_rsp_valid,
    output core_rsp_t            core_rsp [NUM_CORES],
    input  logic [NUM_CORES-1:0] core_rsp_ready
);

    // **************************************************
    // arbitration
    // **************************************************

    logic [NUM_CORES-1:0]     req_eligible;
    logic                     grant_found;
    logic [CORE_IDX_BITS-1:0] grant_idx;
    logic [CORE_IDX_BITS-1:0] last_grant;
    logic                     slot_can_load;
    logic                     grant_fire;
    core_req_t                grant_src;
    mem_req_t                 grant_req;

    assign req_eligible  = core_req_valid & core_enable; // disabled cores are never granted.
    assign slot_can_load = !mem_req_valid || mem_req_ready; // slot empty or draining now.

    always_comb begin
        int unsigned idx;
        grant_found = 1'b0;
        grant_idx   = '0;
        for (int k = 0; k < NUM_CORES; k++) begin
            if (arb_mode == ARB_FIXED_PRIORITY) begin
                idx = k;
            end else begin
                idx = (int'(last_grant) + 1 + k) % NUM_CORES; // start past the last winner.
            end
            if (!grant_found && req_eligible[idx]) begin
                grant_found = 1'b1;
                grant_idx   = CORE_IDX_BITS'(idx);
            end
        end
    end

    assign grant_fire     = grant_found && slot_can_load;
    assign core_req_ready = grant_fire ? (NUM_CORES'(1) << grant_idx) : '0;

    assign grant_src = core_req[grant_idx];

    always_comb begin
        grant_req.op   = grant_src.op;
        grant_req.addr = grant_src.addr;
        grant_req.data = grant_src.data;
        grant_req.tag  = {grant_idx, grant_src.tag}; // the core index rides above the tag.
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_grant <= CORE_IDX_BITS'(NUM_CORES - 1); // so that core 0 comes first.
        end else if (grant_fire) begin
            last_grant <= grant_idx;
        end
    end

    // **************************************************
    // output slot
    // **************************************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_req_valid <= 1'b0;
        end else if (grant_fire) begin
            mem_req_valid <= 1'b1;
        end else if (mem_req_ready) begin
            mem_req_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (grant_fire) begin
            mem_req <= grant_req; // holds while the memory stalls.
        end
    end

    assign slot_full = mem_req_valid;

    // **************************************************
    // response routing
    // **************************************************

    logic [CORE_IDX_BITS-1:0] rsp_core;
    logic [NUM_CORES-1:0]     rsp_sel;

    assign rsp_core = mem_rsp.tag[MEM_TAG_BITS-1 -: CORE_IDX_BITS];

    for (genvar i = 0; i < NUM_CORES; i++) begin : g_rsp
        assign rsp_sel[i]        = (rsp_core == CORE_IDX_BITS'(i));
        assign core_rsp_valid[i] = mem_rsp_valid && rsp_sel[i];
        assign core_rsp[i]       = '{data: mem_rsp.data, tag: mem_rsp.tag[CORE_TAG_BITS-1:0]};
    end

    assign mem_rsp_ready = |(core_rsp_ready & rsp_sel); // back-pressure from the target core.

endmodule

//--- source/cluster_dcr_regs.sv
`timescale 1ns/10ps

module cluster_dcr_regs
    import cluster_cfg_pkg::*;
#(
    parameter int NUM_CORES = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,

    // configuration write strobe
    input  logic                     dcr_wr_valid,
    input  dcr_addr_e                dcr_wr_addr,
    input  logic [DCR_DATA_BITS-1:0] dcr_wr_data,

    // steering outputs to the memory multiplexer
    output logic [NUM_CORES-1:0]     core_enable,
    output arb_mode_e                arb_mode
);

    // **************************************************
    // register decode
    // **************************************************

    logic wr_core_enable;
    logic wr_arb_mode;

    always_comb begin
        wr_core_enable = 1'b0;
        wr_arb_mode    = 1'b0;
        if (dcr_wr_valid) begin
            case (dcr_wr_addr)
                DCR_CORE_ENABLE: wr_core_enable = 1'b1;
                DCR_ARB_MODE:    wr_arb_mode    = 1'b1;
                default: ; // unknown addresses leave every register alone.
            endcase
        end
    end

    // **************************************************
    // registers
    // **************************************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            core_enable <= '1; // all cores take part after reset.
        end else if (wr_core_enable) begin
            core_enable <= dcr_wr_data[NUM_CORES-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            arb_mode <= ARB_ROUND_ROBIN;
        end else if (wr_arb_mode) begin
            arb_mode <= arb_mode_e'(dcr_wr_data[0]);
        end
    end

endmodule

//--- source/mem_types_pkg.sv
package mem_types_pkg;

    import cluster_cfg_pkg::*;

    localparam int ADDR_BITS = 32;
    localparam int DATA_BITS = 32;

    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

    // requests and responses as seen by a core.
    typedef struct packed {
        mem_op_e                  op;
        logic [ADDR_BITS-1:0]     addr;
        logic [DATA_BITS-1:0]     data; // write data, don't care for reads.
        logic [CORE_TAG_BITS-1:0] tag;
    } core_req_t;

    typedef struct packed {
        logic [DATA_BITS-1:0]     data;
        logic [CORE_TAG_BITS-1:0] tag;
    } core_rsp_t;

    // Memory side. The core index sits above the core tag.
    typedef struct packed {
        mem_op_e                 op;
        logic [ADDR_BITS-1:0]    addr;
        logic [DATA_BITS-1:0]    data;
        logic [MEM_TAG_BITS-1:0] tag;
    } mem_req_t;

    typedef struct packed {
        logic [DATA_BITS-1:0]    data;
        logic [MEM_TAG_BITS-1:0] tag;
    } mem_rsp_t;

endpackage

//--- source/cluster_cfg_pkg.sv
package cluster_cfg_pkg;

    // **************************************************
    // cluster sizes
    // **************************************************

    localparam int CORE_IDX_BITS = 2; // enough to name up to four cores.
    localparam int CORE_TAG_BITS = 4; // each core keeps its own tag space.
    localparam int MEM_TAG_BITS  = CORE_IDX_BITS + CORE_TAG_BITS;

    localparam int DCR_DATA_BITS = 32;

    // **************************************************
    // configuration registers
    // **************************************************

    typedef enum logic [3:0] {
        DCR_CORE_ENABLE = 4'h0, // one enable bit per core in the low data bits.
        DCR_ARB_MODE    = 4'h1  // arbitration mode in data bit 0.
    } dcr_addr_e;

    typedef enum logic {
        ARB_ROUND_ROBIN    = 1'b0,
        ARB_FIXED_PRIORITY = 1'b1 // the lowest core index always wins.
    } arb_mode_e;

endpackage
